//--- tl_memory_slave.f
+incdir+design
design/tl_mem_pkg.sv
design/tl_request_decode.sv
design/tl_memory_execute.sv
design/tl_response_sequencer.sv
design/tl_memory_slave.sv
testbench/tl_slave_monitor.sv
testbench/tl_memory_slave_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the TileLink memory slave testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tl_memory_slave_tb \
	-f tl_memory_slave.f \
	-o tl_memory_slave_sim

./obj_dir/tl_memory_slave_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation finished without failure"

//--- testbench/tl_memory_slave_tb.sv
`include "tl_mem_config.svh"

module tl_memory_slave_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int wait_limit = 200;

	logic              clock;
	logic              reset;
	tl_mem_pkg::tl_a_t a;
	logic              a_valid;
	logic              a_ready;
	tl_mem_pkg::tl_d_t d;
	logic              d_valid;
	logic              d_ready;
	logic [2:0]        test_id;
	logic              random_ready;
	int                timeouts;

	tl_memory_slave DUT (
		.clock   (clock),
		.reset   (reset),
		.a       (a),
		.a_valid (a_valid),
		.a_ready (a_ready),
		.d       (d),
		.d_valid (d_valid),
		.d_ready (d_ready)
	);

	tl_slave_monitor monitor (
		.clock   (clock),
		.reset   (reset),
		.test_id (test_id),
		.a       (a),
		.a_valid (a_valid),
		.a_ready (a_ready),
		.d       (d),
		.d_valid (d_valid),
		.d_ready (d_ready)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#10;
			clock = ~clock;
		end
	end

	function automatic logic [31:0] word_address(input int word);
		return `TL_MEM_BASE + 32'(4 * word);
	endfunction

	function automatic tl_mem_pkg::tl_a_t request(input tl_mem_pkg::tl_a_opcode_e opcode,
			input logic [2:0] param, input logic [3:0] size, input logic [31:0] address,
			input logic [3:0] mask, input logic [31:0] data);
		tl_mem_pkg::tl_a_t req;
		req.opcode = opcode;
		req.param.arith = tl_mem_pkg::tl_arith_e'(param);
		req.size = size;
		req.source = 1'($urandom);
		req.address = address;
		req.mask = mask;
		req.data = data;
		return req;
	endfunction

	// Inputs change 2 ns after the rising edge
	task automatic step();
		@(posedge clock);
		#2;
		d_ready = random_ready ? 1'($urandom) : 1'b1;
	endtask

	task automatic send_request(input tl_mem_pkg::tl_a_t req);
		int cycles;
		bit done;
		if (timeouts != 0)
			return;
		a = req;
		a_valid = 1'b1;
		cycles = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clock);
			if (a_ready) begin
				done = 1'b1;
			end else if (cycles == wait_limit) begin
				$display("Timeout in test %0d: a_ready never came up", test_id);
				timeouts++;
				done = 1'b1;
			end
			step();
			cycles++;
		end
		a_valid = 1'b0;
	endtask

	task automatic wait_idle();
		int cycles;
		bit done;
		if (timeouts != 0)
			return;
		cycles = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clock);
			if (!d_valid) begin
				done = 1'b1;
			end else if (cycles == wait_limit) begin
				$display("Timeout in test %0d: response beats never finished", test_id);
				timeouts++;
				done = 1'b1;
			end
			step();
			cycles++;
		end
	endtask

	task automatic finish_run();
		$display("Errors: %0d failed checks, %0d timeouts", monitor.errors, timeouts);
		if (monitor.errors == 0 && timeouts == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	initial begin
		logic [31:0] address;
		int kind;
		void'($urandom(98292));
		reset = 1'b1;
		a = '0;
		a_valid = 1'b0;
		d_ready = 1'b1;
		test_id = 3'd0;
		random_ready = 1'b0;
		timeouts = 0;
		repeat (16) @(posedge clock);
		#2;
		reset = 1'b0;
		step();

		// Cleared words read back before the fill
		test_id = 3'd1;
		send_request(request(tl_mem_pkg::get, 3'd0, 4'd4, word_address(0), 4'hf, 32'd0));
		wait_idle();

		// Whole memory gets an address-derived pattern first
		for (int w = 0; w < `TL_MEM_WORDS; w++) begin
			address = word_address(w);
			send_request(request(tl_mem_pkg::put_full_data, 3'd0, 4'd2, address, 4'hf,
				address * 32'h9e37_79b1 ^ 32'h5a5a_0f0f));
		end
		for (int size = 0; size <= 4; size++) begin
			address = word_address(4 * size);
			if (size == 0)
				address = address + 32'd3;
			if (size == 1)
				address = address + 32'd2;
			send_request(request(tl_mem_pkg::get, 3'd0, 4'(size), address, 4'hf, 32'd0));
			wait_idle();
		end

		test_id = 3'd2;
		for (int i = 0; i < 12; i++) begin
			address = word_address(int'($urandom % 16));
			send_request(request(tl_mem_pkg::put_full_data, 3'd0, 4'd2, address, 4'h0, $urandom));
			send_request(request(tl_mem_pkg::put_partial_data, 3'd0, 4'd2, address,
				4'($urandom), $urandom));
			send_request(request(tl_mem_pkg::get, 3'd0, 4'd2, address, 4'hf, 32'd0));
			wait_idle();
		end
		for (int lane = 0; lane < 4; lane++)
			send_request(request(tl_mem_pkg::put_full_data, 3'd0, 4'd0,
				word_address(20) + 32'(lane), 4'h0, $urandom));
		send_request(request(tl_mem_pkg::put_full_data, 3'd0, 4'd1, word_address(21) + 32'd2,
			4'h0, $urandom));
		send_request(request(tl_mem_pkg::get, 3'd0, 4'd3, word_address(20), 4'hf, 32'd0));
		wait_idle();

		// Codes 0 to 4 arithmetic, 5 to 8 logical
		test_id = 3'd3;
		for (int code = 0; code < 9; code++) begin
			for (int rep = 0; rep < 2; rep++) begin
				address = word_address(32 + code);
				send_request(request(tl_mem_pkg::put_full_data, 3'd0, 4'd2, address, 4'hf,
					$urandom));
				if (code < 5)
					send_request(request(tl_mem_pkg::arithmetic_data, 3'(code), 4'd2, address,
						rep == 0 ? 4'hf : 4'($urandom), $urandom));
				else
					send_request(request(tl_mem_pkg::logical_data, 3'(code - 5), 4'd2, address,
						rep == 0 ? 4'hf : 4'($urandom), $urandom));
				send_request(request(tl_mem_pkg::get, 3'd0, 4'd2, address, 4'hf, 32'd0));
				wait_idle();
			end
		end

		test_id = 3'd4;
		send_request(request(tl_mem_pkg::intent, 3'd0, 4'd2, word_address(8), 4'hf, 32'd0));
		send_request(request(tl_mem_pkg::get, 3'd0, 4'd2, word_address(`TL_MEM_WORDS), 4'hf,
			32'd0));
		send_request(request(tl_mem_pkg::put_full_data, 3'd0, 4'd2, `TL_MEM_BASE - 32'd4,
			4'hf, $urandom));
		send_request(request(tl_mem_pkg::get, 3'd0, 4'd5, word_address(0), 4'hf, 32'd0));
		send_request(request(tl_mem_pkg::put_full_data, 3'd0, 4'd3, word_address(8), 4'hf,
			$urandom));
		send_request(request(tl_mem_pkg::put_partial_data, 3'd0, 4'd3, word_address(10), 4'hf,
			$urandom));
		send_request(request(tl_mem_pkg::logical_data, 3'd3, 4'd3, word_address(8), 4'hf,
			$urandom));
		send_request(request(tl_mem_pkg::get, 3'd0, 4'd2, word_address(1) + 32'd2, 4'hf, 32'd0));
		send_request(request(tl_mem_pkg::get, 3'd0, 4'd4, word_address(8), 4'hf, 32'd0));
		wait_idle();

		// Back-to-back requests under random d_ready
		test_id = 3'd5;
		random_ready = 1'b1;
		for (int i = 0; i < 40; i++) begin
			address = word_address(4 * int'($urandom % 16));
			kind = int'($urandom % 4);
			case (kind)
				0: send_request(request(tl_mem_pkg::get, 3'd0, 4'd4, address, 4'hf, 32'd0));
				1: send_request(request(tl_mem_pkg::put_partial_data, 3'd0, 4'd2, address,
					4'($urandom), $urandom));
				2: send_request(request(tl_mem_pkg::arithmetic_data, 3'($urandom % 5), 4'd2,
					address, 4'hf, $urandom));
				default: send_request(request(tl_mem_pkg::get, 3'd0, 4'd3, address, 4'hf,
					32'd0));
			endcase
		end
		wait_idle();
		random_ready = 1'b0;
		step();
		step();
		finish_run();
	end

endmodule

//--- testbench/tl_slave_monitor.sv
`include "tl_mem_config.svh"

module tl_slave_monitor (
	input logic              clock,
	input logic              reset,
	input logic [2:0]        test_id,
	input tl_mem_pkg::tl_a_t a,
	input logic              a_valid,
	input logic              a_ready,
	input tl_mem_pkg::tl_d_t d,
	input logic              d_valid,
	input logic              d_ready
);
	timeunit 1ns;
	timeprecision 100ps;

	int                errors = 0;
	logic [31:0]       shadow [`TL_MEM_WORDS];
	tl_mem_pkg::tl_d_t expected [$];
	tl_mem_pkg::tl_d_t held_d;
	logic              held = 1'b0;
	logic              settled = 1'b0;

	function automatic string test_name();
		case (test_id)
			3'd1: return "get_sizes";
			3'd2: return "puts";
			3'd3: return "atomics";
			3'd4: return "hint_and_errors";
			3'd5: return "back_pressure";
			default: return "reset";
		endcase
	endfunction

	task automatic fail_check(input string what);
		errors++;
		$display("Check failed in %s: %s", test_name(), what);
	endtask

	task automatic fail_value(input string what, input tl_mem_pkg::tl_d_t want,
			input tl_mem_pkg::tl_d_t got);
		errors++;
		$display("Mismatch in %s: %s expected %h, actual %h", test_name(), what, want, got);
	endtask

	function automatic logic [31:0] combined(input tl_mem_pkg::tl_a_t req, input logic [31:0] old);
		logic [31:0] x;
		x = req.data;
		if (req.opcode == tl_mem_pkg::logical_data) begin
			case (req.param.logical)
				tl_mem_pkg::logic_xor: return old ^ x;
				tl_mem_pkg::logic_or: return old | x;
				tl_mem_pkg::logic_and: return old & x;
				default: return x;
			endcase
		end
		case (req.param.arith)
			tl_mem_pkg::arith_min: return ($signed(x) < $signed(old)) ? x : old;
			tl_mem_pkg::arith_max: return ($signed(x) > $signed(old)) ? x : old;
			tl_mem_pkg::arith_minu: return (x < old) ? x : old;
			tl_mem_pkg::arith_maxu: return (x > old) ? x : old;
			default: return old + x;
		endcase
	endfunction

	// Queue the expected beats and apply the write to the shadow
	task automatic record_request(input tl_mem_pkg::tl_a_t req);
		tl_mem_pkg::tl_d_t     beat;
		tl_mem_pkg::tl_index_t word;
		logic [31:0]           offset;
		logic [31:0]           update;
		logic [3:0]            lanes;
		logic                  bad;
		int                    beats;
		offset = req.address - `TL_MEM_BASE;
		bad = offset >= 32'(4 * `TL_MEM_WORDS) || req.address % (32'd1 << req.size) != 0;
		if (req.opcode == tl_mem_pkg::get)
			bad = bad || req.size > 4'(`TL_MAX_SIZE);
		else if (req.opcode != tl_mem_pkg::intent)
			bad = bad || req.size > 4'd2;
		word = bad ? '0 : tl_mem_pkg::tl_index_t'(offset >> 2);
		beat = '0;
		beat.size = req.size;
		beat.source = req.source;
		beat.error = bad;
		beat.opcode = tl_mem_pkg::access_ack;
		if (req.opcode inside {tl_mem_pkg::get, tl_mem_pkg::arithmetic_data,
				tl_mem_pkg::logical_data})
			beat.opcode = tl_mem_pkg::access_ack_data;
		if (req.opcode == tl_mem_pkg::intent)
			beat.opcode = tl_mem_pkg::hint_ack;
		beats = 1;
		if (req.opcode == tl_mem_pkg::get && !bad && req.size > 4'd2)
			beats = 1 << (int'(req.size) - 2);
		// Atomics answer with the word before the update
		for (int k = 0; k < beats; k++) begin
			if (beat.opcode == tl_mem_pkg::access_ack_data && !bad)
				beat.data = shadow[word + tl_mem_pkg::tl_index_t'(k)];
			expected.push_back(beat);
		end
		if (bad || req.opcode inside {tl_mem_pkg::get, tl_mem_pkg::intent})
			return;
		lanes = req.mask;
		if (req.opcode == tl_mem_pkg::put_full_data) begin
			case (req.size)
				4'd0: lanes = 4'b0001 << req.address[1:0];
				4'd1: lanes = req.address[1] ? 4'b1100 : 4'b0011;
				default: lanes = 4'b1111;
			endcase
		end
		update = req.data;
		if (req.opcode inside {tl_mem_pkg::arithmetic_data, tl_mem_pkg::logical_data})
			update = combined(req, shadow[word]);
		for (int b = 0; b < 4; b++)
			if (lanes[b])
				shadow[word][8*b +: 8] = update[8*b +: 8];
	endtask

	// Falling edge, both sides stable until the next rising edge
	always @(negedge clock) begin
		if (reset) begin
			assert (!a_ready && !d_valid) else fail_check("a_ready or d_valid high during reset");
			expected.delete();
			for (int i = 0; i < `TL_MEM_WORDS; i++)
				shadow[i] = '0;
		end else begin
			if (held) begin
				assert (d_valid) else fail_check("d_valid dropped before the beat was taken");
				assert (d == held_d) else fail_value("held d beat", held_d, d);
			end
			assert (d_valid == (expected.size() != 0))
				else fail_check("d_valid does not match the pending beats");
			if (d_valid) begin
				assert (a_ready == (d_ready && expected.size() == 1))
					else fail_check("a_ready wrong while a response is pending");
			end else if (settled) begin
				assert (a_ready) else fail_check("a_ready low while the slave is idle");
			end
			if (d_valid && d_ready && expected.size() != 0) begin
				assert (d == expected[0]) else fail_value("d beat", expected[0], d);
				void'(expected.pop_front());
			end
			if (a_valid && a_ready)
				record_request(a);
		end
		held = !reset && d_valid && !d_ready;
		held_d = d;
		settled = !reset;
	end

endmodule

//--- design/tl_memory_slave.sv
module tl_memory_slave (
	input  logic              clock,
	input  logic              reset,

	input  tl_mem_pkg::tl_a_t a,
	input  logic              a_valid,
	output logic              a_ready,

	output tl_mem_pkg::tl_d_t d,
	output logic              d_valid,
	input  logic              d_ready
);
	tl_mem_pkg::tl_op_t decoded;
	tl_mem_pkg::tl_op_t current;
	logic               accept;
	logic [1:0]         beat_index;
	logic [31:0]        beat_data;

	tl_request_decode request_decode (
		.a       (a),
		.decoded (decoded)
	);

	// Commits writes and atomics on the accept edge
	tl_memory_execute memory_execute (
		.clock      (clock),
		.reset      (reset),
		.decoded    (decoded),
		.accept     (accept),
		.beat_index (beat_index),
		.current    (current),
		.beat_data  (beat_data)
	);

	tl_response_sequencer response_sequencer (
		.clock      (clock),
		.reset      (reset),
		.a_valid    (a_valid),
		.a_ready    (a_ready),
		.current    (current),
		.beat_data  (beat_data),
		.accept     (accept),
		.beat_index (beat_index),
		.d          (d),
		.d_valid    (d_valid),
		.d_ready    (d_ready)
	);

endmodule

//--- design/tl_response_sequencer.sv
module tl_response_sequencer (
	input  logic               clock,
	input  logic               reset,
	input  logic               a_valid,
	output logic               a_ready,
	input  tl_mem_pkg::tl_op_t current,
	input  logic [31:0]        beat_data,
	output logic               accept,
	output logic [1:0]         beat_index,
	output tl_mem_pkg::tl_d_t  d,
	output logic               d_valid,
	input  logic               d_ready
);
	logic busy;
	logic running;
	logic last;
	logic d_fire;
	logic has_data;

	assign last = {1'b0, beat_index} == current.beats - 3'd1;
	assign d_valid = busy;
	assign d_fire = d_valid && d_ready;

	// Idle, or handing off on the last beat
	assign a_ready = running && (!busy || (last && d_ready));
	assign accept = a_valid && a_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			running <= 1'b0;
			busy <= 1'b0;
			beat_index <= '0;
		end else begin
			running <= 1'b1;
			if (accept) begin
				busy <= 1'b1;
				beat_index <= '0;
			end else if (d_fire) begin
				if (last) begin
					busy <= 1'b0;
				end else begin
					beat_index <= beat_index + 2'd1;
				end
			end
		end
	end

	always_comb begin
		case (current.opcode)
			tl_mem_pkg::get,
			tl_mem_pkg::arithmetic_data,
			tl_mem_pkg::logical_data: begin
				d.opcode = tl_mem_pkg::access_ack_data;
			end
			tl_mem_pkg::intent: begin
				d.opcode = tl_mem_pkg::hint_ack;
			end
			default: begin
				d.opcode = tl_mem_pkg::access_ack;
			end
		endcase

		d.param = '0;
		d.size = current.size;
		d.source = current.source;
		d.sink = 1'b0;
		d.error = current.error;

		// No data on acks without payload or on errors
		has_data = d.opcode == tl_mem_pkg::access_ack_data && !current.error;
		d.data = has_data ? beat_data : '0;
	end

endmodule

//--- design/tl_memory_execute.sv
`include "tl_mem_config.svh"

module tl_memory_execute (
	input  logic               clock,
	input  logic               reset,
	input  tl_mem_pkg::tl_op_t decoded,
	input  logic               accept,
	input  logic [1:0]         beat_index,
	output tl_mem_pkg::tl_op_t current,
	output logic [31:0]        beat_data
);
	logic [31:0] mem [`TL_MEM_WORDS];

	logic [31:0]           stored_word;
	logic [31:0]           new_word;
	logic [31:0]           old_word;
	logic                  is_write;
	logic                  write_en;
	tl_mem_pkg::tl_index_t read_index;

	function automatic logic [31:0] atomic_result(
		input tl_mem_pkg::tl_op_t op,
		input logic [31:0]        old
	);
		logic [31:0] result;
		result = old;
		if (op.opcode == tl_mem_pkg::arithmetic_data) begin
			case (op.param.arith)
				tl_mem_pkg::arith_min:
					result = ($signed(old) < $signed(op.data)) ? old : op.data;
				tl_mem_pkg::arith_max:
					result = ($signed(old) > $signed(op.data)) ? old : op.data;
				tl_mem_pkg::arith_minu:
					result = (old < op.data) ? old : op.data;
				tl_mem_pkg::arith_maxu:
					result = (old > op.data) ? old : op.data;
				tl_mem_pkg::arith_add:
					result = old + op.data;
				default:
					result = old;
			endcase
		end else begin
			case (op.param.logical)
				tl_mem_pkg::logic_xor: result = old ^ op.data;
				tl_mem_pkg::logic_or: result = old | op.data;
				tl_mem_pkg::logic_and: result = old & op.data;
				tl_mem_pkg::logic_swap: result = op.data;
				default: result = old;
			endcase
		end
		return result;
	endfunction

	function automatic logic [31:0] merge_bytes(
		input logic [31:0] old,
		input logic [31:0] update,
		input logic [3:0]  mask
	);
		logic [31:0] merged;
		for (int i = 0; i < 4; i++) begin
			merged[8*i +: 8] = mask[i] ? update[8*i +: 8] : old[8*i +: 8];
		end
		return merged;
	endfunction

	assign stored_word = mem[decoded.index];

	always_comb begin
		is_write = 1'b0;
		new_word = decoded.data;
		case (decoded.opcode)
			tl_mem_pkg::put_full_data,
			tl_mem_pkg::put_partial_data: begin
				is_write = 1'b1;
			end
			tl_mem_pkg::arithmetic_data,
			tl_mem_pkg::logical_data: begin
				is_write = 1'b1;
				new_word = atomic_result(decoded, stored_word);
			end
			default: begin
				is_write = 1'b0;
			end
		endcase
	end

	// Errored requests never touch memory
	assign write_en = accept && is_write && !decoded.error;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `TL_MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (write_en) begin
			mem[decoded.index] <= merge_bytes(stored_word, new_word, decoded.mask);
		end
	end

	// Old word is the atomic response, captured before the update lands
	always_ff @(posedge clock) begin
		if (accept) begin
			current <= decoded;
			old_word <= stored_word;
		end
	end

	assign read_index = current.index + tl_mem_pkg::tl_index_t'(beat_index);
	assign beat_data = (current.opcode == tl_mem_pkg::get) ? mem[read_index] : old_word;

endmodule

//--- design/tl_request_decode.sv
`include "tl_mem_config.svh"

module tl_request_decode (
	input  tl_mem_pkg::tl_a_t  a,
	output tl_mem_pkg::tl_op_t decoded
);
	localparam int index_bits = $bits(tl_mem_pkg::tl_index_t);
	localparam logic [31:0] mem_bytes = `TL_MEM_WORDS * 4;

	logic [31:0] offset;
	logic [31:0] bytes;
	logic        out_of_range;
	logic        misaligned;
	logic        too_large;
	logic        bad_opcode;
	logic [3:0]  full_mask;

	always_comb begin
		// Below the base wraps to a large offset
		offset = a.address - `TL_MEM_BASE;
		bytes = 32'd1 << a.size;

		// Aligned transfers never cross the end of memory
		out_of_range = offset >= mem_bytes;
		misaligned = (a.address & (bytes - 32'd1)) != '0;

		too_large = 1'b0;
		bad_opcode = 1'b0;
		case (a.opcode)
			tl_mem_pkg::get: begin
				too_large = a.size > 4'(`TL_MAX_SIZE);
			end
			tl_mem_pkg::put_full_data,
			tl_mem_pkg::put_partial_data,
			tl_mem_pkg::arithmetic_data,
			tl_mem_pkg::logical_data: begin
				// Single beat only
				too_large = a.size > 4'd2;
			end
			tl_mem_pkg::intent: begin
				too_large = 1'b0;
			end
			default: begin
				bad_opcode = 1'b1;
			end
		endcase

		// Lanes covered by a full write of this size
		case (a.size)
			4'd0: full_mask = 4'b0001 << a.address[1:0];
			4'd1: full_mask = 4'b0011 << {a.address[1], 1'b0};
			default: full_mask = 4'b1111;
		endcase

		decoded.opcode = a.opcode;
		decoded.param = a.param;
		decoded.size = a.size;
		decoded.source = a.source;
		decoded.index = offset[index_bits+1:2];
		decoded.mask = (a.opcode == tl_mem_pkg::put_full_data) ? full_mask : a.mask;
		decoded.data = a.data;
		decoded.error = out_of_range || misaligned || too_large || bad_opcode;

		// One beat per word for Get, otherwise one
		decoded.beats = 3'd1;
		if (a.opcode == tl_mem_pkg::get && a.size > 4'd2 && !decoded.error) begin
			decoded.beats = 3'd1 << (a.size - 4'd2);
		end
	end

endmodule

//--- design/tl_mem_pkg.sv
package tl_mem_pkg;

	`include "tl_mem_config.svh"

	// A channel opcodes, TL-UL and TL-UH
	typedef enum logic [2:0] {
		put_full_data    = 3'd0,
		put_partial_data = 3'd1,
		arithmetic_data  = 3'd2,
		logical_data     = 3'd3,
		get              = 3'd4,
		intent           = 3'd5
	} tl_a_opcode_e;

	typedef enum logic [2:0] {
		access_ack      = 3'd0,
		access_ack_data = 3'd1,
		hint_ack        = 3'd2
	} tl_d_opcode_e;

	typedef enum logic [2:0] {
		arith_min  = 3'd0,
		arith_max  = 3'd1,
		arith_minu = 3'd2,
		arith_maxu = 3'd3,
		arith_add  = 3'd4
	} tl_arith_e;

	typedef enum logic [2:0] {
		logic_xor  = 3'd0,
		logic_or   = 3'd1,
		logic_and  = 3'd2,
		logic_swap = 3'd3
	} tl_logic_e;

	// Param field, meaning depends on the atomic opcode
	typedef union packed {
		tl_arith_e arith;
		tl_logic_e logical;
	} tl_atomic_param_u;

	typedef logic [$clog2(`TL_MEM_WORDS)-1:0] tl_index_t;

	typedef struct packed {
		tl_a_opcode_e     opcode;
		tl_atomic_param_u param;
		logic [3:0]       size;
		logic             source;
		logic [31:0]      address;
		logic [3:0]       mask;
		logic [31:0]      data;
	} tl_a_t;

	typedef struct packed {
		tl_d_opcode_e opcode;
		logic [1:0]   param;
		logic [3:0]   size;
		logic         source;
		logic         sink;
		logic         error;
		logic [31:0]  data;
	} tl_d_t;

	// Request after decode, held for the whole response
	typedef struct packed {
		tl_a_opcode_e     opcode;
		tl_atomic_param_u param;
		logic [3:0]       size;
		logic             source;
		tl_index_t        index;
		logic [3:0]       mask;
		logic [31:0]      data;
		logic             error;
		logic [2:0]       beats;
	} tl_op_t;

endpackage

//--- design/tl_mem_config.svh
`ifndef TL_MEM_CONFIG_SVH
`define TL_MEM_CONFIG_SVH

// Number of 32-bit words in the memory
`define TL_MEM_WORDS 64

// Byte address of word zero, same as the core reset vector
`define TL_MEM_BASE 32'h0001_0000

// Largest log2 byte size of a Get
`define TL_MAX_SIZE 4

`endif
